// ==== design/soc_pkg.sv ====
// shared widths, address map and pipeline records for the tile wrapper
package soc_pkg;

  typedef logic [63:0] addr_t;
  typedef logic [63:0] data_t;
  typedef logic [31:0] offset_t;

  // destination class picked by the address decoder
  typedef enum logic [1:0] {
    ROUTE_NOC  = 2'd0,
    ROUTE_CTRL = 2'd1,
    ROUTE_ERR  = 2'd2
  } route_e;

  // address map
  localparam addr_t DramBase   = 64'h0000_0000_8000_0000;
  localparam addr_t DramLength = 64'h0000_0000_4000_0000;
  localparam addr_t CtrlBase   = 64'h0000_0000_D000_0000;
  localparam addr_t CtrlLength = 64'h0000_0000_0000_1000;

  // register offsets inside the control window
  localparam offset_t RegExitOff  = 32'h0000_0000;
  localparam offset_t RegHwCntOff = 32'h0000_0008;
  localparam offset_t RegEventOff = 32'h0000_0010;

  // opcode in the top byte of a header flit
  localparam logic [7:0] NocWriteOp = 8'h52;

  typedef struct packed {
    logic  write;
    addr_t addr;
    data_t wdata;
  } req_t;

  typedef struct packed {
    req_t   req;
    route_e route;
  } dec_req_t;

  typedef struct packed {
    logic    write;
    route_e  route;
    offset_t offset;
    data_t   wdata;
    data_t   rdata;
    logic    err;
  } exe_req_t;

  typedef struct packed {
    data_t rdata;
    logic  err;
  } rsp_t;

endpackage

// ==== design/reset_wakeup.sv ====
// wake-up counter that holds the tile in reset, then releases it through a synchronizer
`timescale 1ns/1ps

module reset_wakeup #(
  parameter int unsigned WakeCntWidth = 16
) (
  input  logic clk_i,
  input  logic reset_l,
  output logic spc_grst_o
);

  logic [WakeCntWidth-1:0] wake_cnt_q;
  logic [WakeCntWidth-1:0] wake_cnt_d;
  logic                    rst_gate;
  logic                    sync_q1;
  logic                    sync_q2;

  // saturates once the top bit is set
  assign wake_cnt_d = wake_cnt_q[WakeCntWidth-1] ? wake_cnt_q : wake_cnt_q + 1'b1;

  always_ff @(posedge clk_i or negedge reset_l) begin
    if (!reset_l) begin
      wake_cnt_q <= '0;
    end else begin
      wake_cnt_q <= wake_cnt_d;
    end
  end

  assign rst_gate = wake_cnt_q[WakeCntWidth-1] & reset_l;

  // two stages before the tile sees the release
  always_ff @(posedge clk_i or negedge reset_l) begin
    if (!reset_l) begin
      sync_q1 <= 1'b0;
      sync_q2 <= 1'b0;
    end else begin
      sync_q1 <= rst_gate;
      sync_q2 <= sync_q1;
    end
  end

  assign spc_grst_o = sync_q2;

endmodule

// ==== design/irq_sync.sv ====
// two-flop synchronizer bank for the asynchronous interrupt and debug lines
`timescale 1ns/1ps

module irq_sync #(
  parameter int unsigned Width = 5
) (
  input  logic             clk_i,
  input  logic             reset_l,
  input  logic [Width-1:0] async_i,
  output logic [Width-1:0] sync_o
);

  logic [Width-1:0] meta_q;
  logic [Width-1:0] sync_q;

  // first stage may go metastable, second one settles it
  always_ff @(posedge clk_i or negedge reset_l) begin
    if (!reset_l) begin
      meta_q <= '0;
      sync_q <= '0;
    end else begin
      meta_q <= async_i;
      sync_q <= meta_q;
    end
  end

  assign sync_o = sync_q;

endmodule

// ==== design/addr_decode.sv ====
// request stage 1, takes in a request and classifies it by address window
`timescale 1ns/1ps

module addr_decode (
  input  logic              clk_i,
  input  logic              reset_l,
  input  logic              req_valid_i,
  input  soc_pkg::req_t     req_i,
  output logic              req_ready_o,
  input  logic              dec_ready_i,
  output logic              dec_valid_o,
  output soc_pkg::dec_req_t dec_o
);

  logic              active_q;
  logic              full_q;
  logic              accept;
  logic              in_dram;
  logic              in_ctrl;
  soc_pkg::dec_req_t dec_d;
  soc_pkg::dec_req_t dec_q;

  // window compares, end address is exclusive
  assign in_dram = (req_i.addr >= soc_pkg::DramBase) &&
                   (req_i.addr < soc_pkg::DramBase + soc_pkg::DramLength);
  assign in_ctrl = (req_i.addr >= soc_pkg::CtrlBase) &&
                   (req_i.addr < soc_pkg::CtrlBase + soc_pkg::CtrlLength);

  always_comb begin
    dec_d.req = req_i;
    if (in_dram) begin
      dec_d.route = soc_pkg::ROUTE_NOC;
    end else if (in_ctrl) begin
      dec_d.route = soc_pkg::ROUTE_CTRL;
    end else begin
      dec_d.route = soc_pkg::ROUTE_ERR;
    end
  end

  // ready opens on the first clock after the tile reset releases
  assign req_ready_o = active_q && (!full_q || dec_ready_i);
  assign accept      = req_valid_i && req_ready_o;

  always_ff @(posedge clk_i or negedge reset_l) begin
    if (!reset_l) begin
      active_q <= 1'b0;
      full_q   <= 1'b0;
    end else begin
      active_q <= 1'b1;
      if (accept) begin
        full_q <= 1'b1;
      end else if (dec_ready_i) begin
        full_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      dec_q <= dec_d;
    end
  end

  assign dec_valid_o = full_q;
  assign dec_o       = dec_q;

endmodule

// ==== design/ctrl_regs.sv ====
// request stage 2, runs control register accesses and flags bad requests
`timescale 1ns/1ps

module ctrl_regs (
  input  logic              clk_i,
  input  logic              reset_l,
  input  logic              dec_valid_i,
  input  soc_pkg::dec_req_t dec_i,
  output logic              dec_ready_o,
  input  logic              exe_ready_i,
  output logic              exe_valid_o,
  output soc_pkg::exe_req_t exe_o,
  output logic              exit_o,
  output logic              hw_cnt_en_o,
  output soc_pkg::data_t    event_trigger_o
);

  logic              full_q;
  logic              load;
  logic              retire;
  logic              known_off;
  soc_pkg::addr_t    ctrl_diff;
  soc_pkg::addr_t    dram_diff;
  soc_pkg::exe_req_t exe_d;
  soc_pkg::exe_req_t exe_q;
  soc_pkg::data_t    reg_rdata;
  logic              exit_q;
  logic              hw_cnt_en_q;
  soc_pkg::data_t    event_q;

  assign dec_ready_o = !full_q || exe_ready_i;
  assign load        = dec_valid_i && dec_ready_o;
  assign retire      = full_q && exe_ready_i;
  assign exe_valid_o = full_q;

  ////////////////////////////////////////////////////////////////////////////
  // item build on entry
  ////////////////////////////////////////////////////////////////////////////

  // both windows fit in 32 bits of offset
  assign ctrl_diff = dec_i.req.addr - soc_pkg::CtrlBase;
  assign dram_diff = dec_i.req.addr - soc_pkg::DramBase;

  assign known_off = (ctrl_diff[31:0] == soc_pkg::RegExitOff)  ||
                     (ctrl_diff[31:0] == soc_pkg::RegHwCntOff) ||
                     (ctrl_diff[31:0] == soc_pkg::RegEventOff);

  always_comb begin
    exe_d.write  = dec_i.req.write;
    exe_d.route  = dec_i.route;
    exe_d.wdata  = dec_i.req.wdata;
    exe_d.rdata  = '0;
    exe_d.offset = (dec_i.route == soc_pkg::ROUTE_NOC) ? dram_diff[31:0] : ctrl_diff[31:0];
    case (dec_i.route)
      soc_pkg::ROUTE_NOC:  exe_d.err = !dec_i.req.write;  // no return path for reads
      soc_pkg::ROUTE_CTRL: exe_d.err = !known_off;
      default:             exe_d.err = 1'b1;
    endcase
  end

  always_ff @(posedge clk_i or negedge reset_l) begin
    if (!reset_l) begin
      full_q <= 1'b0;
    end else if (load) begin
      full_q <= 1'b1;
    end else if (retire) begin
      full_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (load) begin
      exe_q <= exe_d;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // register file
  ////////////////////////////////////////////////////////////////////////////

  // read late, so older writes that already left are seen
  always_comb begin
    case (exe_q.offset)
      soc_pkg::RegExitOff:  reg_rdata = {{63{1'b0}}, exit_q};
      soc_pkg::RegHwCntOff: reg_rdata = {{63{1'b0}}, hw_cnt_en_q};
      soc_pkg::RegEventOff: reg_rdata = event_q;
      default:              reg_rdata = '0;
    endcase
  end

  always_comb begin
    exe_o = exe_q;
    if (exe_q.route == soc_pkg::ROUTE_CTRL && !exe_q.write && !exe_q.err) begin
      exe_o.rdata = reg_rdata;
    end
  end

  // write lands once, as the item moves on to stage 3
  always_ff @(posedge clk_i or negedge reset_l) begin
    if (!reset_l) begin
      exit_q      <= 1'b0;
      hw_cnt_en_q <= 1'b0;
      event_q     <= '0;
    end else if (retire && exe_q.route == soc_pkg::ROUTE_CTRL && exe_q.write && !exe_q.err) begin
      case (exe_q.offset)
        soc_pkg::RegExitOff:  exit_q      <= exe_q.wdata[0];
        soc_pkg::RegHwCntOff: hw_cnt_en_q <= exe_q.wdata[0];
        soc_pkg::RegEventOff: event_q     <= exe_q.wdata;
        default: ;
      endcase
    end
  end

  assign exit_o          = exit_q;
  assign hw_cnt_en_o     = hw_cnt_en_q;
  assign event_trigger_o = event_q;

endmodule

// ==== design/noc_bridge.sv ====
// request stage 3, turns DRAM writes into NoC flits and returns every response
`timescale 1ns/1ps

module noc_bridge (
  input  logic              clk_i,
  input  logic              reset_l,
  input  logic              exe_valid_i,
  input  soc_pkg::exe_req_t exe_i,
  output logic              exe_ready_o,
  output logic              noc_valid_o,
  output soc_pkg::data_t    noc_data_o,
  input  logic              noc_ready_i,
  output logic              rsp_valid_o,
  output soc_pkg::rsp_t     rsp_o
);

  typedef enum logic [1:0] {
    IDLE = 2'd0,
    HDR  = 2'd1,
    DATA = 2'd2,
    RSP  = 2'd3
  } state_e;

  state_e            state_q;
  state_e            state_d;
  logic              accept;
  soc_pkg::exe_req_t item_q;

  // busy only while flits are out
  assign exe_ready_o = (state_q == IDLE) || (state_q == RSP);
  assign accept      = exe_valid_i && exe_ready_o;

  ////////////////////////////////////////////////////////////////////////////
  // state machine
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE, RSP: begin
        if (accept) begin
          state_d = (exe_i.route == soc_pkg::ROUTE_NOC && !exe_i.err) ? HDR : RSP;
        end else begin
          state_d = IDLE;
        end
      end
      HDR: begin
        if (noc_ready_i) begin
          state_d = DATA;
        end
      end
      DATA: begin
        if (noc_ready_i) begin
          state_d = RSP;
        end
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge reset_l) begin
    if (!reset_l) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      item_q <= exe_i;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // flit and response outputs
  ////////////////////////////////////////////////////////////////////////////

  // header is opcode, zero pad, then the DRAM offset
  assign noc_valid_o = (state_q == HDR) || (state_q == DATA);
  assign noc_data_o  = (state_q == HDR) ? {soc_pkg::NocWriteOp, 24'h0, item_q.offset}
                                        : item_q.wdata;

  // DRAM writes carry zero rdata and clear err from stage 2
  assign rsp_valid_o = (state_q == RSP);
  assign rsp_o.rdata = item_q.rdata;
  assign rsp_o.err   = item_q.err;

endmodule

// ==== design/soc_wrap_top.sv ====
// tile wrapper top with wake-up reset, interrupt synchronizers and request pipeline
`timescale 1ns/1ps

module soc_wrap_top #(
  parameter int unsigned WakeCntWidth = 16
) (
  input  logic           clk_i,
  input  logic           reset_l,
  // request port
  input  logic           req_valid_i,
  input  soc_pkg::req_t  req_i,
  output logic           req_ready_o,
  output logic           rsp_valid_o,
  output soc_pkg::rsp_t  rsp_o,
  // NoC output
  output logic           noc_valid_o,
  output soc_pkg::data_t noc_data_o,
  input  logic           noc_ready_i,
  // interrupts
  input  logic [1:0]     irq_i,
  input  logic           ipi_i,
  input  logic           time_irq_i,
  input  logic           debug_req_i,
  output logic [1:0]     irq_o,
  output logic           ipi_o,
  output logic           time_irq_o,
  output logic           debug_req_o,
  // reset and control
  output logic           spc_grst_o,
  output logic           exit_o,
  output logic           hw_cnt_en_o,
  output soc_pkg::data_t event_trigger_o
);

  logic              dec_valid;
  logic              dec_ready;
  soc_pkg::dec_req_t dec_req;
  logic              exe_valid;
  logic              exe_ready;
  soc_pkg::exe_req_t exe_req;
  logic [4:0]        irq_sync;

  ////////////////////////////////////////////////////////////////////////////
  // reset gate and synchronizers
  ////////////////////////////////////////////////////////////////////////////

  reset_wakeup #(
    .WakeCntWidth (WakeCntWidth)
  ) u_reset_wakeup (
    .clk_i      (clk_i),
    .reset_l    (reset_l),
    .spc_grst_o (spc_grst_o)
  );

  // bit order is irq[1:0], ipi, timer, debug from the bottom up
  irq_sync #(
    .Width (5)
  ) u_irq_sync (
    .clk_i   (clk_i),
    .reset_l (reset_l),
    .async_i ({debug_req_i, time_irq_i, ipi_i, irq_i}),
    .sync_o  (irq_sync)
  );

  assign irq_o       = irq_sync[1:0];
  assign ipi_o       = irq_sync[2];
  assign time_irq_o  = irq_sync[3];
  assign debug_req_o = irq_sync[4];

  ////////////////////////////////////////////////////////////////////////////
  // request pipeline, decode then registers then NoC
  ////////////////////////////////////////////////////////////////////////////

  addr_decode u_addr_decode (
    .clk_i       (clk_i),
    .reset_l     (spc_grst_o),
    .req_valid_i (req_valid_i),
    .req_i       (req_i),
    .req_ready_o (req_ready_o),
    .dec_ready_i (dec_ready),
    .dec_valid_o (dec_valid),
    .dec_o       (dec_req)
  );

  ctrl_regs u_ctrl_regs (
    .clk_i           (clk_i),
    .reset_l         (spc_grst_o),
    .dec_valid_i     (dec_valid),
    .dec_i           (dec_req),
    .dec_ready_o     (dec_ready),
    .exe_ready_i     (exe_ready),
    .exe_valid_o     (exe_valid),
    .exe_o           (exe_req),
    .exit_o          (exit_o),
    .hw_cnt_en_o     (hw_cnt_en_o),
    .event_trigger_o (event_trigger_o)
  );

  noc_bridge u_noc_bridge (
    .clk_i       (clk_i),
    .reset_l     (spc_grst_o),
    .exe_valid_i (exe_valid),
    .exe_i       (exe_req),
    .exe_ready_o (exe_ready),
    .noc_valid_o (noc_valid_o),
    .noc_data_o  (noc_data_o),
    .noc_ready_i (noc_ready_i),
    .rsp_valid_o (rsp_valid_o),
    .rsp_o       (rsp_o)
  );

endmodule

// ==== testbench/soc_wrap_assert.sv ====
// protocol assertions on the tile wrapper ports, bound into the top level
`timescale 1ns/1ps

module soc_wrap_assert (
  input logic           clk_i,
  input logic           reset_l,
  input logic           spc_grst_o,
  input logic           req_ready_o,
  input logic           rsp_valid_o,
  input logic           noc_valid_o,
  input soc_pkg::data_t noc_data_o,
  input logic           noc_ready_i
);

  // a stalled flit holds until the NoC takes it
  noc_hold_a: assert property (
    @(posedge clk_i) disable iff (!spc_grst_o)
    (noc_valid_o && !noc_ready_i) |=> (noc_valid_o && $stable(noc_data_o))
  ) else $error("NoC flit dropped or changed while stalled");

  quiet_in_reset_a: assert property (
    @(posedge clk_i) disable iff (!reset_l)
    !spc_grst_o |-> (!rsp_valid_o && !noc_valid_o)
  ) else $error("response or flit while the tile is in reset");

  ready_in_reset_a: assert property (
    @(posedge clk_i) disable iff (!reset_l)
    !spc_grst_o |-> !req_ready_o
  ) else $error("request ready while the tile is in reset");

endmodule

bind soc_wrap_top soc_wrap_assert u_soc_wrap_assert (
  .clk_i       (clk_i),
  .reset_l     (reset_l),
  .spc_grst_o  (spc_grst_o),
  .req_ready_o (req_ready_o),
  .rsp_valid_o (rsp_valid_o),
  .noc_valid_o (noc_valid_o),
  .noc_data_o  (noc_data_o),
  .noc_ready_i (noc_ready_i)
);

// ==== testbench/tb_soc_wrap.sv ====
// testbench for the tile wrapper, covering reset release, interrupt sync and the request path
`timescale 1ns/1ps

module tb_soc_wrap;

  localparam int NumTests  = 20;
  localparam int MaxCycles = NumTests * 20 + 200;

  typedef struct packed {
    logic           write;
    soc_pkg::addr_t addr;
    soc_pkg::data_t wdata;
    soc_pkg::data_t exp_rdata;
    logic           exp_err;
    int             exp_flits;
    logic           chk_lat;
    logic           bp;
  } test_t;

  logic           clk_i;
  logic           reset_l;
  logic           req_valid_i;
  soc_pkg::req_t  req_i;
  logic           req_ready_o;
  logic           rsp_valid_o;
  soc_pkg::rsp_t  rsp_o;
  logic           noc_valid_o;
  soc_pkg::data_t noc_data_o;
  logic           noc_ready_i;
  logic [1:0]     irq_i;
  logic           ipi_i;
  logic           time_irq_i;
  logic           debug_req_i;
  logic [1:0]     irq_o;
  logic           ipi_o;
  logic           time_irq_o;
  logic           debug_req_o;
  logic           spc_grst_o;
  logic           exit_o;
  logic           hw_cnt_en_o;
  soc_pkg::data_t event_trigger_o;

  test_t          tests [NumTests];
  int             acc_cycle [NumTests];
  soc_pkg::data_t flit_q [$];
  int             cycle_cnt = 0;
  int             issued = 0;
  int             rsp_idx = 0;
  // main process and response monitor keep their own counts
  int             main_errs = 0;
  int             main_run = 0;
  int             main_failed = 0;
  int             mon_errs = 0;
  int             mon_run = 0;
  int             mon_failed = 0;
  logic           rand_mode;
  logic [31:0]    lcg_state;
  logic           exp_exit = 1'b0;
  logic           exp_hw = 1'b0;
  soc_pkg::data_t exp_event = '0;

  soc_wrap_top #(
    .WakeCntWidth (5)
  ) u_soc_wrap_top (
    .clk_i           (clk_i),
    .reset_l         (reset_l),
    .req_valid_i     (req_valid_i),
    .req_i           (req_i),
    .req_ready_o     (req_ready_o),
    .rsp_valid_o     (rsp_valid_o),
    .rsp_o           (rsp_o),
    .noc_valid_o     (noc_valid_o),
    .noc_data_o      (noc_data_o),
    .noc_ready_i     (noc_ready_i),
    .irq_i           (irq_i),
    .ipi_i           (ipi_i),
    .time_irq_i      (time_irq_i),
    .debug_req_i     (debug_req_i),
    .irq_o           (irq_o),
    .ipi_o           (ipi_o),
    .time_irq_o      (time_irq_o),
    .debug_req_o     (debug_req_o),
    .spc_grst_o      (spc_grst_o),
    .exit_o          (exit_o),
    .hw_cnt_en_o     (hw_cnt_en_o),
    .event_trigger_o (event_trigger_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  always @(posedge clk_i) cycle_cnt <= cycle_cnt + 1;

  initial begin
    wait (cycle_cnt > MaxCycles);
    $display("timeout after %0d cycles, %0d of %0d responses seen", cycle_cnt, rsp_idx, NumTests);
    $display("ERRORS FOUND");
    $finish;
  end

  ////////////////////////////////////////////////////////////////////////////
  // helpers
  ////////////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  task automatic show_mismatch(input string name, input soc_pkg::data_t got,
                               input soc_pkg::data_t exp);
    $display("[FAIL] %0t %s: got %0h, expected %0h", $time, name, got, exp);
  endtask

  task automatic set_test(input int idx, input logic w, input soc_pkg::addr_t a,
                          input soc_pkg::data_t wd, input soc_pkg::data_t rd, input logic e,
                          input int fl, input logic lat, input logic stall);
    tests[idx] = '{write: w, addr: a, wdata: wd, exp_rdata: rd, exp_err: e,
                   exp_flits: fl, chk_lat: lat, bp: stall};
  endtask

  task automatic load_tests();
    // control registers, NoC ready held high
    set_test(0, 1'b1, 64'hD000_0000, 64'h1, 64'h0, 1'b0, 0, 1'b1, 1'b0);
    set_test(1, 1'b1, 64'hD000_0008, 64'h3, 64'h0, 1'b0, 0, 1'b1, 1'b0);
    set_test(2, 1'b1, 64'hD000_0010, 64'h1234_5678_9ABC_DEF0, 64'h0, 1'b0, 0, 1'b1, 1'b0);
    set_test(3, 1'b0, 64'hD000_0000, 64'h0, 64'h1, 1'b0, 0, 1'b1, 1'b0);
    set_test(4, 1'b0, 64'hD000_0008, 64'h0, 64'h1, 1'b0, 0, 1'b1, 1'b0);
    set_test(5, 1'b0, 64'hD000_0010, 64'h0, 64'h1234_5678_9ABC_DEF0, 1'b0, 0, 1'b1, 1'b0);
    // error cases
    set_test(6, 1'b1, 64'h0000_1000, 64'hDEAD, 64'h0, 1'b1, 0, 1'b1, 1'b0);
    set_test(7, 1'b0, 64'hD000_0018, 64'h0, 64'h0, 1'b1, 0, 1'b1, 1'b0);
    set_test(8, 1'b1, 64'hD000_0020, 64'hFF, 64'h0, 1'b1, 0, 1'b1, 1'b0);
    set_test(9, 1'b0, 64'h8000_0040, 64'h0, 64'h0, 1'b1, 0, 1'b1, 1'b0);
    set_test(10, 1'b0, 64'hC000_0000, 64'h0, 64'h0, 1'b1, 0, 1'b1, 1'b0);
    // DRAM writes, then a mixed stream, all under random NoC stalls
    set_test(11, 1'b1, 64'h8000_0100, 64'hA5A5_A5A5_5A5A_5A5A, 64'h0, 1'b0, 2, 1'b0, 1'b1);
    set_test(12, 1'b1, 64'hBFFF_FFF8, 64'h0123_4567_89AB_CDEF, 64'h0, 1'b0, 2, 1'b0, 1'b1);
    set_test(13, 1'b1, 64'hD000_0000, 64'h0, 64'h0, 1'b0, 0, 1'b0, 1'b1);
    set_test(14, 1'b1, 64'h8000_2000, 64'hFEED_F00D, 64'h0, 1'b0, 2, 1'b0, 1'b1);
    set_test(15, 1'b0, 64'hD000_0000, 64'h0, 64'h0, 1'b0, 0, 1'b0, 1'b1);
    set_test(16, 1'b0, 64'hFFFF_0000_0000_0000, 64'h0, 64'h0, 1'b1, 0, 1'b0, 1'b1);
    set_test(17, 1'b1, 64'h8000_0008, 64'h1111_2222, 64'h0, 1'b0, 2, 1'b0, 1'b1);
    set_test(18, 1'b1, 64'hD000_0010, 64'h55, 64'h0, 1'b0, 0, 1'b0, 1'b1);
    set_test(19, 1'b0, 64'hD000_0010, 64'h0, 64'h55, 1'b0, 0, 1'b0, 1'b1);
  endtask

  task automatic check_irq(input logic [4:0] pat, input logic [4:0] prev);
    logic [4:0] got;
    @(posedge clk_i);
    #2;
    {debug_req_i, time_irq_i, ipi_i, irq_i} = pat;
    // one edge in, only the first flop holds it
    @(posedge clk_i);
    #3;
    got = {debug_req_o, time_irq_o, ipi_o, irq_o};
    if (got !== prev) begin
      show_mismatch("irq outputs one cycle later", 64'(got), 64'(prev));
      main_errs++;
    end
    @(posedge clk_i);
    #3;
    got = {debug_req_o, time_irq_o, ipi_o, irq_o};
    if (got !== pat) begin
      show_mismatch("irq outputs two cycles later", 64'(got), 64'(pat));
      main_errs++;
    end
  endtask

  task automatic finish_main_test(input string name, input int errs_before);
    main_run++;
    if (main_errs != errs_before) begin
      main_failed++;
      $display("test %s: failed", name);
    end else begin
      $display("test %s: ok", name);
    end
  endtask

  // returns at one ns after an edge once every request has its response
  task automatic wait_drain();
    @(posedge clk_i);
    #1;
    while (rsp_idx < issued) begin
      @(posedge clk_i);
      #1;
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // response monitor
  ////////////////////////////////////////////////////////////////////////////

  task automatic check_response();
    test_t          t;
    soc_pkg::addr_t diff;
    soc_pkg::data_t hdr;
    int             bad;
    bad = 0;
    if (rsp_idx >= issued) begin
      $display("response at %0t with no request outstanding", $time);
      mon_errs++;
    end else begin
      t = tests[rsp_idx];
      if (rsp_o.err !== t.exp_err) begin
        show_mismatch("rsp_o.err", 64'(rsp_o.err), 64'(t.exp_err));
        bad++;
      end
      if (rsp_o.rdata !== t.exp_rdata) begin
        show_mismatch("rsp_o.rdata", rsp_o.rdata, t.exp_rdata);
        bad++;
      end
      if (flit_q.size() != t.exp_flits) begin
        $display("test %0d saw %0d NoC flits, expected %0d", rsp_idx, flit_q.size(), t.exp_flits);
        bad++;
      end else if (t.exp_flits == 2) begin
        // header is opcode, 24 zero bits, offset from the DRAM base
        diff = t.addr - soc_pkg::DramBase;
        hdr  = {soc_pkg::NocWriteOp, 24'h0, diff[31:0]};
        if (flit_q[0] !== hdr) begin
          show_mismatch("noc_data_o header", flit_q[0], hdr);
          bad++;
        end
        if (flit_q[1] !== t.wdata) begin
          show_mismatch("noc_data_o data", flit_q[1], t.wdata);
          bad++;
        end
      end
      flit_q.delete();
      if (t.chk_lat && (cycle_cnt - acc_cycle[rsp_idx] != 3)) begin
        $display("test %0d response came %0d cycles after acceptance instead of 3",
                 rsp_idx, cycle_cnt - acc_cycle[rsp_idx]);
        bad++;
      end
      // register model, only good control writes change it
      if (t.write && !t.exp_err && t.addr >= soc_pkg::CtrlBase &&
          t.addr < soc_pkg::CtrlBase + soc_pkg::CtrlLength) begin
        diff = t.addr - soc_pkg::CtrlBase;
        case (diff[31:0])
          soc_pkg::RegExitOff:  exp_exit = t.wdata[0];
          soc_pkg::RegHwCntOff: exp_hw = t.wdata[0];
          soc_pkg::RegEventOff: exp_event = t.wdata;
          default: ;
        endcase
      end
      if (exit_o !== exp_exit) begin
        show_mismatch("exit_o", 64'(exit_o), 64'(exp_exit));
        bad++;
      end
      if (hw_cnt_en_o !== exp_hw) begin
        show_mismatch("hw_cnt_en_o", 64'(hw_cnt_en_o), 64'(exp_hw));
        bad++;
      end
      if (event_trigger_o !== exp_event) begin
        show_mismatch("event_trigger_o", event_trigger_o, exp_event);
        bad++;
      end
      mon_run++;
      mon_errs += bad;
      if (bad != 0) begin
        mon_failed++;
      end
      $display("test %0d addr %h: %s", rsp_idx, t.addr, (bad != 0) ? "failed" : "ok");
      rsp_idx++;
    end
  endtask

  // sampled well clear of the input drive point
  initial begin
    forever begin
      @(posedge clk_i);
      #5;
      if (noc_valid_o === 1'b1 && noc_ready_i === 1'b1) begin
        flit_q.push_back(noc_data_o);
      end
      if (rsp_valid_o === 1'b1) begin
        check_response();
      end
    end
  end

  // NoC ready, random only in the stalled part of the table
  initial begin
    noc_ready_i = 1'b1;
    lcg_state   = 32'd65;
    forever begin
      @(posedge clk_i);
      #2;
      lcg_state   = lcg_next(lcg_state);
      noc_ready_i = rand_mode ? lcg_state[16] : 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    int n;
    int errs_before;
    reset_l     = 1'b0;
    req_valid_i = 1'b0;
    req_i       = '0;
    irq_i       = 2'b00;
    ipi_i       = 1'b0;
    time_irq_i  = 1'b0;
    debug_req_i = 1'b0;
    rand_mode   = 1'b0;
    load_tests();
    repeat (4) @(posedge clk_i);
    #2;
    reset_l = 1'b1;

    // tile reset release, 16 counts plus 2 sync stages
    errs_before = main_errs;
    n = 0;
    while (spc_grst_o !== 1'b1) begin
      if ({req_ready_o, rsp_valid_o, noc_valid_o, exit_o, hw_cnt_en_o} !== 5'b0 ||
          event_trigger_o !== '0) begin
        $display("outputs active at %0t while the tile is still in reset", $time);
        main_errs++;
      end
      @(posedge clk_i);
      #3;
      n++;
    end
    if (n < 17 || n > 19) begin
      show_mismatch("spc_grst_o release cycle", 64'(n), 64'd18);
      main_errs++;
    end
    finish_main_test("reset release", errs_before);

    // every line gets its own rise and fall history
    errs_before = main_errs;
    check_irq(5'b01001, 5'b00000);
    check_irq(5'b11010, 5'b01001);
    check_irq(5'b10100, 5'b11010);
    check_irq(5'b00000, 5'b10100);
    finish_main_test("interrupt sync", errs_before);

    // request table, back to back where the pipeline allows
    @(posedge clk_i);
    #2;
    for (int i = 0; i < NumTests; i++) begin
      if (tests[i].bp != rand_mode) begin
        req_valid_i = 1'b0;
        wait_drain();
        rand_mode = tests[i].bp;
        #1;
      end
      req_valid_i    = 1'b1;
      req_i.write    = tests[i].write;
      req_i.addr     = tests[i].addr;
      req_i.wdata    = tests[i].wdata;
      #1;
      while (req_ready_o !== 1'b1) begin
        @(posedge clk_i);
        #3;
      end
      acc_cycle[i] = cycle_cnt;
      issued       = i + 1;
      @(posedge clk_i);
      #2;
    end
    req_valid_i = 1'b0;
    wait_drain();
    repeat (4) @(posedge clk_i);

    if (rsp_idx != NumTests || flit_q.size() != 0) begin
      $display("%0d of %0d responses seen, %0d flits left over", rsp_idx, NumTests,
               flit_q.size());
      main_errs++;
    end
    $display("tests run %0d, failed %0d, errors %0d", main_run + mon_run,
             main_failed + mon_failed, main_errs + mon_errs);
    if (main_errs + mon_errs == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

// ==== files.f ====
design/soc_pkg.sv
design/reset_wakeup.sv
design/irq_sync.sv
design/addr_decode.sv
design/ctrl_regs.sv
design/noc_bridge.sv
design/soc_wrap_top.sv
testbench/soc_wrap_assert.sv
testbench/tb_soc_wrap.sv

// ==== run.sh ====
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log
verilator --binary --timing --assert -f files.f --top-module tb_soc_wrap -o tb_soc_wrap \
  > build.log 2>&1 \
  && ./obj_dir/tb_soc_wrap > sim.log 2>&1 \
  || { echo "build or simulation failed, see build.log and sim.log"; exit 1; }
grep -q "^NO ERRORS$" sim.log \
  && echo "simulation passed" \
  || { echo "simulation failed, see sim.log"; exit 1; }
